//--- hw/nocPkg.sv
package nocPkg;

  localparam int NUM_PORTS = 5;

  typedef logic [2:0] portIdxT;
  typedef logic [NUM_PORTS-1:0] portMaskT;

  // the port indices follow the order in which the arbiters rotate.
  localparam portIdxT PORT_L = 3'd0;
  localparam portIdxT PORT_N = 3'd1;
  localparam portIdxT PORT_E = 3'd2;
  localparam portIdxT PORT_W = 3'd3;
  localparam portIdxT PORT_S = 3'd4;

  typedef logic [2:0] flitIdT;

  localparam flitIdT FLIT_HEAD = 3'b001;
  localparam flitIdT FLIT_BODY = 3'b010;
  localparam flitIdT FLIT_TAIL = 3'b100;

  typedef logic [19:0] payloadT;
  typedef logic [3:0] coordT;
  typedef logic [11:0] pktLenT;

  // a header payload is {destX, destY, length}.
  localparam int X_LSB = 16;
  localparam int Y_LSB = 12;

  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_L,
    ARB_N,
    ARB_E,
    ARB_W,
    ARB_S
  } arbStateT;

endpackage

//--- hw/inputBuffer.sv
`timescale 1ns/10ps

module inputBuffer #(
  parameter int BUF_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wrValid,
  input  nocPkg::flitIdT  wrFlitId,
  input  nocPkg::payloadT wrPayload,
  input  logic            pop,
  output nocPkg::flitIdT  headFlitId,
  output nocPkg::payloadT headPayload,
  output logic            empty,
  output logic            full
);

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  nocPkg::flitIdT  flitMem [BUF_DEPTH];
  nocPkg::payloadT payloadMem [BUF_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic doWrite;
  logic doPop;

  function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(BUF_DEPTH - 1))
      nextPtr = '0;
    else
      nextPtr = ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full = (count == CNT_W'(BUF_DEPTH));
  assign doWrite = wrValid && !full;
  assign doPop = pop && !empty;

  // the head entry is read straight from storage.
  assign headFlitId = flitMem[rdPtr];
  assign headPayload = payloadMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      flitMem[wrPtr] <= wrFlitId;
      payloadMem[wrPtr] <= wrPayload;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      if (doWrite && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doWrite)
        count <= count - 1'b1;
    end
  end

  // senders watch the full level, and the crossbar only pops a buffer it sees non-empty.
  assert property (@(posedge clk) disable iff (rst) wrValid |-> !full);
  assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- hw/routeCompute.sv
`timescale 1ns/10ps

module routeCompute #(
  parameter nocPkg::coordT MY_X = 4'd0,
  parameter nocPkg::coordT MY_Y = 4'd0
) (
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::flitIdT   headFlitId [nocPkg::NUM_PORTS],
  input  nocPkg::payloadT  headPayload [nocPkg::NUM_PORTS],
  input  logic             empty [nocPkg::NUM_PORTS],
  input  nocPkg::portIdxT  sel [nocPkg::NUM_PORTS],
  input  logic             pktRelease [nocPkg::NUM_PORTS],
  output nocPkg::portMaskT outReq [nocPkg::NUM_PORTS],
  output nocPkg::pktLenT   inLen [nocPkg::NUM_PORTS]
);

  logic            held [nocPkg::NUM_PORTS];
  logic            isHeader [nocPkg::NUM_PORTS];
  nocPkg::coordT   destX [nocPkg::NUM_PORTS];
  nocPkg::coordT   destY [nocPkg::NUM_PORTS];
  nocPkg::portIdxT routeNew [nocPkg::NUM_PORTS];
  nocPkg::portIdxT routeReg [nocPkg::NUM_PORTS];
  nocPkg::portIdxT route [nocPkg::NUM_PORTS];
  nocPkg::pktLenT  lenReg [nocPkg::NUM_PORTS];

  for (genvar i = 0; i < nocPkg::NUM_PORTS; i++)
  begin : gInput
    assign isHeader[i] = !empty[i] && (headFlitId[i] == nocPkg::FLIT_HEAD);
    assign destX[i] = nocPkg::coordT'(headPayload[i] >> nocPkg::X_LSB);
    assign destY[i] = nocPkg::coordT'(headPayload[i] >> nocPkg::Y_LSB);

    // dimension order routing resolves X before Y.
    always_comb
    begin
      if (destX[i] > MY_X)
        routeNew[i] = nocPkg::PORT_E;
      else if (destX[i] < MY_X)
        routeNew[i] = nocPkg::PORT_W;
      else if (destY[i] > MY_Y)
        routeNew[i] = nocPkg::PORT_N;
      else if (destY[i] < MY_Y)
        routeNew[i] = nocPkg::PORT_S;
      else
        routeNew[i] = nocPkg::PORT_L;
    end

    // a fresh header requests in the same cycle so that the arbiter can grant at the latch edge.
    assign route[i] = held[i] ? routeReg[i] : routeNew[i];
    assign inLen[i] = held[i] ? lenReg[i] : nocPkg::pktLenT'(headPayload[i]);

    always_ff @(posedge clk)
    begin
      if (rst)
        held[i] <= 1'b0;
      else if (held[i] && pktRelease[routeReg[i]] && (sel[routeReg[i]] == nocPkg::portIdxT'(i)))
        held[i] <= 1'b0;
      else if (!held[i] && isHeader[i])
        held[i] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
      if (!held[i] && isHeader[i])
      begin
        routeReg[i] <= routeNew[i];
        lenReg[i] <= nocPkg::pktLenT'(headPayload[i]);
      end
    end

    assert property (@(posedge clk) disable iff (rst)
      (!held[i] && isHeader[i]) |-> (inLen[i] >= 12'd2));
  end

  always_comb
  begin
    for (int o = 0; o < nocPkg::NUM_PORTS; o++)
    begin
      for (int i = 0; i < nocPkg::NUM_PORTS; i++)
        outReq[o][i] = (held[i] || isHeader[i]) && (route[i] == nocPkg::portIdxT'(o));
    end
  end

endmodule

//--- hw/outputArbiter.sv
`timescale 1ns/10ps

module outputArbiter (
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::portMaskT req,
  input  nocPkg::portMaskT empty,
  input  nocPkg::pktLenT   inLen [nocPkg::NUM_PORTS],
  output nocPkg::portIdxT  sel,
  output logic             fwd,
  output logic             pktRelease
);

  nocPkg::arbStateT state;
  nocPkg::arbStateT nextState;
  nocPkg::pktLenT   flitCount;
  nocPkg::pktLenT   lastIdx;
  nocPkg::portIdxT  nextSel;
  logic granted;
  logic regrant;
  logic pick;
  int   scanStart;
  int   scanIdx;

  function automatic nocPkg::arbStateT stateOf(nocPkg::portIdxT idx);
    case (idx)
      nocPkg::PORT_L: stateOf = nocPkg::ARB_L;
      nocPkg::PORT_N: stateOf = nocPkg::ARB_N;
      nocPkg::PORT_E: stateOf = nocPkg::ARB_E;
      nocPkg::PORT_W: stateOf = nocPkg::ARB_W;
      nocPkg::PORT_S: stateOf = nocPkg::ARB_S;
      default:        stateOf = nocPkg::ARB_IDLE;
    endcase
  endfunction

  // sel follows the state register, so it only moves at a clock edge.
  always_comb
  begin
    case (state)
      nocPkg::ARB_N: sel = nocPkg::PORT_N;
      nocPkg::ARB_E: sel = nocPkg::PORT_E;
      nocPkg::ARB_W: sel = nocPkg::PORT_W;
      nocPkg::ARB_S: sel = nocPkg::PORT_S;
      default:       sel = nocPkg::PORT_L;
    endcase
  end

  assign granted = (state != nocPkg::ARB_IDLE);
  assign fwd = granted && !empty[sel];
  assign pktRelease = fwd && (flitCount == lastIdx);

  // the grant may move only from idle or on the last flit of the current packet.
  assign regrant = !granted || pktRelease;

  // from idle the scan starts at Local, otherwise just after the current input.
  always_comb
  begin
    scanStart = granted ? int'(sel) + 1 : 0;
    scanIdx = 0;
    pick = 1'b0;
    nextSel = nocPkg::PORT_L;
    for (int k = 0; k < nocPkg::NUM_PORTS; k++)
    begin
      scanIdx = scanStart + k;
      if (scanIdx >= nocPkg::NUM_PORTS)
        scanIdx = scanIdx - nocPkg::NUM_PORTS;
      if (!pick && req[scanIdx] && !(granted && (scanIdx == int'(sel))))
      begin
        pick = 1'b1;
        nextSel = nocPkg::portIdxT'(scanIdx);
      end
    end
  end

  always_comb
  begin
    nextState = state;
    if (regrant)
      nextState = pick ? stateOf(nextSel) : nocPkg::ARB_IDLE;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::ARB_IDLE;
      flitCount <= '0;
      lastIdx <= '0;
    end
    else
    begin
      state <= nextState;
      if (regrant && pick)
      begin
        // the packet timer loads the new owner's length.
        flitCount <= '0;
        lastIdx <= inLen[nextSel] - 1'b1;
      end
      else if (fwd)
      begin
        flitCount <= flitCount + 1'b1;
      end
    end
  end

  // the route stage must keep the request up for as long as the worm holds this output.
  assert property (@(posedge clk) disable iff (rst) granted |-> req[sel]);

endmodule

//--- hw/crossbar.sv
`timescale 1ns/10ps

module crossbar (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::portIdxT sel [nocPkg::NUM_PORTS],
  input  logic            fwd [nocPkg::NUM_PORTS],
  input  nocPkg::flitIdT  headFlitId [nocPkg::NUM_PORTS],
  input  nocPkg::payloadT headPayload [nocPkg::NUM_PORTS],
  output logic            pop [nocPkg::NUM_PORTS],
  output logic            outValid [nocPkg::NUM_PORTS],
  output nocPkg::flitIdT  outFlitId [nocPkg::NUM_PORTS],
  output nocPkg::payloadT outPayload [nocPkg::NUM_PORTS]
);

  // each input has a row with a bit for every output that forwards from it.
  nocPkg::portMaskT popMask [nocPkg::NUM_PORTS];

  always_comb
  begin
    for (int i = 0; i < nocPkg::NUM_PORTS; i++)
    begin
      for (int o = 0; o < nocPkg::NUM_PORTS; o++)
        popMask[i][o] = fwd[o] && (sel[o] == nocPkg::portIdxT'(i));
    end
  end

  for (genvar i = 0; i < nocPkg::NUM_PORTS; i++)
  begin : gPop
    assign pop[i] = |popMask[i];

    // routing holds one output per input, so two arbiters never share a source.
    assert property (@(posedge clk) disable iff (rst) $onehot0(popMask[i]));
  end

  for (genvar o = 0; o < nocPkg::NUM_PORTS; o++)
  begin : gOut
    always_ff @(posedge clk)
    begin
      if (rst)
        outValid[o] <= 1'b0;
      else
        outValid[o] <= fwd[o];
    end

    always_ff @(posedge clk)
    begin
      if (fwd[o])
      begin
        outFlitId[o] <= headFlitId[sel[o]];
        outPayload[o] <= headPayload[sel[o]];
      end
    end
  end

endmodule

//--- hw/meshRouter.sv
`timescale 1ns/10ps

module meshRouter #(
  parameter nocPkg::coordT MY_X = 4'd0,
  parameter nocPkg::coordT MY_Y = 4'd0,
  parameter int BUF_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValid [nocPkg::NUM_PORTS],
  input  nocPkg::flitIdT  inFlitId [nocPkg::NUM_PORTS],
  input  nocPkg::payloadT inPayload [nocPkg::NUM_PORTS],
  output logic            inFull [nocPkg::NUM_PORTS],
  output logic            outValid [nocPkg::NUM_PORTS],
  output nocPkg::flitIdT  outFlitId [nocPkg::NUM_PORTS],
  output nocPkg::payloadT outPayload [nocPkg::NUM_PORTS]
);

  nocPkg::flitIdT   headFlitId [nocPkg::NUM_PORTS];
  nocPkg::payloadT  headPayload [nocPkg::NUM_PORTS];
  logic             bufEmpty [nocPkg::NUM_PORTS];
  wire nocPkg::portMaskT emptyMask;
  logic             pop [nocPkg::NUM_PORTS];
  nocPkg::portMaskT outReq [nocPkg::NUM_PORTS];
  nocPkg::pktLenT   inLen [nocPkg::NUM_PORTS];
  nocPkg::portIdxT  sel [nocPkg::NUM_PORTS];
  logic             fwd [nocPkg::NUM_PORTS];
  logic             pktRelease [nocPkg::NUM_PORTS];

  for (genvar i = 0; i < nocPkg::NUM_PORTS; i++)
  begin : gBuf
    inputBuffer #(
      .BUF_DEPTH (BUF_DEPTH)
    ) uInputBuffer (
      .clk         (clk),
      .rst         (rst),
      .wrValid     (inValid[i]),
      .wrFlitId    (inFlitId[i]),
      .wrPayload   (inPayload[i]),
      .pop         (pop[i]),
      .headFlitId  (headFlitId[i]),
      .headPayload (headPayload[i]),
      .empty       (emptyMask[i]),
      .full        (inFull[i])
    );

    assign bufEmpty[i] = emptyMask[i];
  end

  routeCompute #(
    .MY_X (MY_X),
    .MY_Y (MY_Y)
  ) uRouteCompute (
    .clk         (clk),
    .rst         (rst),
    .headFlitId  (headFlitId),
    .headPayload (headPayload),
    .empty       (bufEmpty),
    .sel         (sel),
    .pktRelease  (pktRelease),
    .outReq      (outReq),
    .inLen       (inLen)
  );

  for (genvar o = 0; o < nocPkg::NUM_PORTS; o++)
  begin : gArb
    outputArbiter uOutputArbiter (
      .clk        (clk),
      .rst        (rst),
      .req        (outReq[o]),
      .empty      (emptyMask),
      .inLen      (inLen),
      .sel        (sel[o]),
      .fwd        (fwd[o]),
      .pktRelease (pktRelease[o])
    );
  end

  crossbar uCrossbar (
    .clk         (clk),
    .rst         (rst),
    .sel         (sel),
    .fwd         (fwd),
    .headFlitId  (headFlitId),
    .headPayload (headPayload),
    .pop         (pop),
    .outValid    (outValid),
    .outFlitId   (outFlitId),
    .outPayload  (outPayload)
  );

endmodule

//--- testbench/routerTb.sv
`timescale 1ns/10ps

module routerTb;

  localparam nocPkg::coordT MY_X = 4'd2;
  localparam nocPkg::coordT MY_Y = 4'd2;
  localparam int NP = nocPkg::NUM_PORTS;
  localparam int TIMEOUT = 2000;
  localparam int RAND_PKTS = 40;

  logic            clk;
  logic            rst;
  logic            inValid [NP];
  nocPkg::flitIdT  inFlitId [NP];
  nocPkg::payloadT inPayload [NP];
  logic            inFull [NP];
  logic            outValid [NP];
  nocPkg::flitIdT  outFlitId [NP];
  nocPkg::payloadT outPayload [NP];

  // flits are kept as {flitId, payload} and the expected ones are queued per output and source.
  logic [22:0] gotQ [NP][$];
  logic [22:0] expQ [NP*NP][$];
  int mismatches;
  int failures;
  int bothValid;
  int westFull;
  logic [31:0] seed;
  int pktSrc [RAND_PKTS];
  int pktX [RAND_PKTS];
  int pktY [RAND_PKTS];
  int pktLen [RAND_PKTS];

  meshRouter #(
    .MY_X      (MY_X),
    .MY_Y      (MY_Y),
    .BUF_DEPTH (4)
  ) DUT (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inFlitId   (inFlitId),
    .inPayload  (inPayload),
    .inFull     (inFull),
    .outValid   (outValid),
    .outFlitId  (outFlitId),
    .outPayload (outPayload)
  );

  initial
    clk = 1'b0;

  always #2 clk = ~clk;

  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int o = 0; o < NP; o++)
      begin
        if (outValid[o])
          gotQ[o].push_back({outFlitId[o], outPayload[o]});
      end
      if (outValid[nocPkg::PORT_E] && outValid[nocPkg::PORT_N])
        bothValid++;
      if (inFull[nocPkg::PORT_W])
        westFull++;
    end
  end

  function automatic int nextRand(int range);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return int'(seed[30:16]) % range;
  endfunction

  // non-header flits carry {source, packet id, flit index}.
  function automatic logic [22:0] flitVal(int src, int id, int dx, int dy, int len, int f);
    nocPkg::flitIdT kind;
    nocPkg::payloadT pay;
    if (f == 0)
    begin
      kind = nocPkg::FLIT_HEAD;
      pay = {4'(dx), 4'(dy), 12'(len)};
    end
    else
    begin
      kind = (f == len - 1) ? nocPkg::FLIT_TAIL : nocPkg::FLIT_BODY;
      pay = {3'(src), 9'(id), 8'(f)};
    end
    return {kind, pay};
  endfunction

  function automatic int xyPort(int dx, int dy);
    if (dx > int'(MY_X))
      return int'(nocPkg::PORT_E);
    if (dx < int'(MY_X))
      return int'(nocPkg::PORT_W);
    if (dy > int'(MY_Y))
      return int'(nocPkg::PORT_N);
    if (dy < int'(MY_Y))
      return int'(nocPkg::PORT_S);
    return int'(nocPkg::PORT_L);
  endfunction

  function automatic int totalGot();
    int sum;
    sum = 0;
    for (int o = 0; o < NP; o++)
      sum += gotQ[o].size();
    return sum;
  endfunction

  task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic reportFailure(string msg);
    failures++;
    $display("ERROR: %s", msg);
  endtask

  task automatic timedOut(string what);
    $display("timeout: %s", what);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic expectPacket(int out, int src, int id, int dx, int dy, int len);
    for (int f = 0; f < len; f++)
      expQ[out * NP + src].push_back(flitVal(src, id, dx, dy, len, f));
  endtask

  // called 1 ns after a rising edge, and returns at the same phase.
  task automatic sendPacket(int src, int id, int dx, int dy, int len);
    int waitCount;
    logic [22:0] flit;
    for (int f = 0; f < len; f++)
    begin
      waitCount = 0;
      while (inFull[src])
      begin
        @(posedge clk);
        #1;
        waitCount++;
        if (waitCount > TIMEOUT)
          timedOut($sformatf("input %0d stayed full", src));
      end
      flit = flitVal(src, id, dx, dy, len, f);
      inValid[src] = 1'b1;
      inFlitId[src] = flit[22:20];
      inPayload[src] = flit[19:0];
      @(posedge clk);
      #1;
      inValid[src] = 1'b0;
    end
  endtask

  task automatic waitDrained();
    int want;
    int waitCount;
    want = 0;
    waitCount = 0;
    for (int k = 0; k < NP * NP; k++)
      want += expQ[k].size();
    while (totalGot() < want)
    begin
      @(posedge clk);
      #1;
      waitCount++;
      if (waitCount > TIMEOUT)
        timedOut("the outputs did not deliver every expected flit");
    end
  endtask

  // splits each output stream into packets and matches each one to its source in order.
  task automatic checkOutputs();
    int pos;
    int src;
    int len;
    logic [22:0] head;
    logic [22:0] second;
    for (int o = 0; o < NP; o++)
    begin
      pos = 0;
      while (pos < gotQ[o].size())
      begin
        head = gotQ[o][pos];
        second = gotQ[o][pos + 1];
        len = int'(head[11:0]);
        src = int'(second[19:17]);
        if (head[22:20] != nocPkg::FLIT_HEAD || src >= NP || len < 2 ||
            pos + len > gotQ[o].size() || expQ[o * NP + src].size() < len)
        begin
          reportFailure($sformatf("output %0d holds a broken or unexpected packet at flit %0d",
                                  o, pos));
          break;
        end
        for (int f = 0; f < len; f++)
          checkVal($sformatf("outFlit[%0d]", o), 32'(gotQ[o][pos + f]),
                   32'(expQ[o * NP + src].pop_front()));
        pos += len;
      end
      for (int s = 0; s < NP; s++)
      begin
        if (expQ[o * NP + s].size() != 0)
          reportFailure($sformatf("output %0d is missing flits from input %0d", o, s));
        expQ[o * NP + s].delete();
      end
      gotQ[o].delete();
    end
  endtask

  task automatic testSingle();
    expectPacket(nocPkg::PORT_E, nocPkg::PORT_L, 1, 3, 2, 4);
    sendPacket(nocPkg::PORT_L, 1, 3, 2, 4);
    waitDrained();
    checkOutputs();
  endtask

  task automatic testXyRouting();
    int dests [5][3];
    dests = '{'{1, 2, 3}, '{2, 3, 1}, '{2, 1, 4}, '{3, 0, 2}, '{2, 2, 0}};
    for (int n = 0; n < 5; n++)
    begin
      expectPacket(dests[n][2], nocPkg::PORT_L, 10 + n, dests[n][0], dests[n][1], 3);
      sendPacket(nocPkg::PORT_L, 10 + n, dests[n][0], dests[n][1], 3);
      waitDrained();
    end
    checkOutputs();
  endtask

  // the West worm waits behind North, so its buffer fills and raises inFull.
  task automatic testWormhole();
    westFull = 0;
    expectPacket(nocPkg::PORT_E, nocPkg::PORT_N, 20, 3, 2, 5);
    expectPacket(nocPkg::PORT_E, nocPkg::PORT_W, 21, 3, 2, 5);
    fork
      sendPacket(nocPkg::PORT_N, 20, 3, 2, 5);
      sendPacket(nocPkg::PORT_W, 21, 3, 2, 5);
    join
    waitDrained();
    checkOutputs();
    if (westFull == 0)
      reportFailure("the blocked West buffer never raised inFull");
    checkVal("inFull[3]", 32'(inFull[nocPkg::PORT_W]), 32'd0);
  endtask

  task automatic testRotation();
    int waitCount;
    int order [4];
    int starts [4];
    logic [22:0] flit;
    order = '{0, 2, 4, 1};
    starts = '{1, 5, 9, 15};
    waitCount = 0;
    expectPacket(nocPkg::PORT_N, nocPkg::PORT_L, 30, 2, 3, 4);
    expectPacket(nocPkg::PORT_N, nocPkg::PORT_E, 31, 2, 3, 4);
    expectPacket(nocPkg::PORT_N, nocPkg::PORT_S, 32, 2, 3, 6);
    expectPacket(nocPkg::PORT_N, nocPkg::PORT_N, 33, 2, 3, 3);
    fork
      sendPacket(nocPkg::PORT_L, 30, 2, 3, 4);
      sendPacket(nocPkg::PORT_E, 31, 2, 3, 4);
      sendPacket(nocPkg::PORT_S, 32, 2, 3, 6);
      begin
        // S owns North once its header follows the eight L and E flits.
        while (gotQ[nocPkg::PORT_N].size() <= 8)
        begin
          @(posedge clk);
          #1;
          waitCount++;
          if (waitCount > TIMEOUT)
            timedOut("the South packet never reached the North output");
        end
        sendPacket(nocPkg::PORT_N, 33, 2, 3, 3);
      end
    join
    waitDrained();
    for (int k = 0; k < 4; k++)
    begin
      flit = gotQ[nocPkg::PORT_N][starts[k]];
      checkVal($sformatf("northSource[%0d]", k), 32'(flit[19:17]), 32'(order[k]));
    end
    checkOutputs();
  endtask

  task automatic testParallel();
    bothValid = 0;
    expectPacket(nocPkg::PORT_E, nocPkg::PORT_L, 40, 3, 2, 5);
    expectPacket(nocPkg::PORT_N, nocPkg::PORT_W, 41, 2, 3, 5);
    fork
      sendPacket(nocPkg::PORT_L, 40, 3, 2, 5);
      sendPacket(nocPkg::PORT_W, 41, 2, 3, 5);
    join
    waitDrained();
    checkOutputs();
    if (bothValid == 0)
      reportFailure("East and North never carried flits in the same cycle");
  endtask

  task automatic sendFrom(int src);
    for (int n = 0; n < RAND_PKTS; n++)
    begin
      if (pktSrc[n] == src)
      begin
        expectPacket(xyPort(pktX[n], pktY[n]), src, 100 + n, pktX[n], pktY[n], pktLen[n]);
        sendPacket(src, 100 + n, pktX[n], pktY[n], pktLen[n]);
      end
    end
  endtask

  task automatic testRandom();
    for (int n = 0; n < RAND_PKTS; n++)
    begin
      pktSrc[n] = nextRand(NP);
      pktX[n] = nextRand(5);
      pktY[n] = nextRand(5);
      pktLen[n] = 2 + nextRand(5);
    end
    fork
      sendFrom(0);
      sendFrom(1);
      sendFrom(2);
      sendFrom(3);
      sendFrom(4);
    join
    waitDrained();
    checkOutputs();
  endtask

  initial
  begin
    seed = 32'h4960;
    mismatches = 0;
    failures = 0;
    bothValid = 0;
    westFull = 0;
    rst = 1'b1;
    for (int p = 0; p < NP; p++)
    begin
      inValid[p] = 1'b0;
      inFlitId[p] = '0;
      inPayload[p] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // every buffer comes out of reset empty.
    for (int p = 0; p < NP; p++)
      checkVal($sformatf("inFull[%0d]", p), 32'(inFull[p]), 32'd0);
    testSingle();
    testXyRouting();
    testWormhole();
    testRotation();
    testParallel();
    testRandom();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- verilog.f
hw/nocPkg.sv
hw/inputBuffer.sv
hw/routeCompute.sv
hw/outputArbiter.sv
hw/crossbar.sv
hw/meshRouter.sv
testbench/routerTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= routerTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
